// File: exec_unit_mux.f
+incdir+include
verilog/exec_mux_pkg.sv
verilog/unit_order_queue.sv
verilog/alu_unit.sv
verilog/mul_unit.sv
verilog/exec_unit_mux.sv
verif/exec_unit_mux_tb.sv

// File: run_sim.sh
#!/usr/bin/env bash
# Build the testbench with Verilator, run it, and judge the result from the log.
set -e

cd "$(dirname "$0")"

LOG=sim.log

verilator --binary --timing -j 0 \
    --top-module exec_unit_mux_tb \
    -f exec_unit_mux.f \
    -o exec_unit_mux_sim

./obj_dir/exec_unit_mux_sim > "$LOG" 2>&1
cat "$LOG"

if grep -q "Verification failed" "$LOG"; then
    echo "Simulation reported failure"
    exit 1
fi

if ! grep -q "Verification passed" "$LOG"; then
    echo "Simulation ended without a result"
    exit 1
fi

exit 0

// File: include/exec_ref.svh
// Reference model and expected-result record for the testbench scoreboard.
// Include inside a scope that imports exec_mux_pkg.

`ifndef EXEC_REF_SVH
`define EXEC_REF_SVH

// One scoreboard entry
typedef struct packed {
    logic [ID_W-1:0]   id;
    logic [DATA_W-1:0] res;
} exec_exp_t;

// Result of one instruction, wrapping at DATA_W bits
function automatic logic [DATA_W-1:0] exec_ref(
    input exec_op            op,
    input logic [DATA_W-1:0] opa,
    input logic [DATA_W-1:0] opb
);
    logic [DATA_W-1:0] a_lo;
    logic [DATA_W-1:0] b_lo;
    a_lo = DATA_W'(opa[MUL_OPND_W-1:0]);
    b_lo = DATA_W'(opb[MUL_OPND_W-1:0]);
    case (op)
        OP_ADD:  return opa + opb;
        OP_SUB:  return opa - opb;
        OP_AND:  return opa & opb;
        OP_XOR:  return opa ^ opb;
        // Unsigned product of the low operand bits
        OP_MUL:  return a_lo * b_lo;
        default: return '0;
    endcase
endfunction

`endif

// File: verif/exec_unit_mux_tb.sv
// Testbench for exec_unit_mux: directed ALU, multiply and ordering tests,
// then a random mix under output back-pressure, checked against a scoreboard.

`timescale 1ns/1ns

module exec_unit_mux_tb import exec_mux_pkg::*; ;

    `include "exec_ref.svh"

    localparam int RESET_CYCLES  = 16;
    localparam int SEND_TIMEOUT  = 300;
    localparam int DRAIN_TIMEOUT = 2000;
    localparam int RANDOM_COUNT  = 300;
    localparam logic [31:0] SEED = 32'h34c;

    logic              clk_i = 1'b0;
    logic              rst_i;
    logic              in_valid_i;
    logic              in_ready_o;
    logic [ID_W-1:0]   in_id_i;
    exec_op            in_op_i;
    logic [DATA_W-1:0] in_opa_i;
    logic [DATA_W-1:0] in_opb_i;
    logic              out_valid_o;
    logic              out_ready_i;
    logic [ID_W-1:0]   out_id_o;
    logic [DATA_W-1:0] out_res_o;

    // Scoreboard is written by the stimulus and read in order by the compare process
    exec_exp_t exp_q[$];
    exec_exp_t cmp_entry;
    int        rd_idx;
    int        out_cnt;
    int        chk_err_cnt;
    int        stim_err_cnt;
    int        pass_cnt;
    int        fail_cnt;
    logic      bp_en;

    exec_unit_mux dut_i (
        .clk_i       ( clk_i       ),
        .rst_i       ( rst_i       ),
        .in_valid_i  ( in_valid_i  ),
        .in_ready_o  ( in_ready_o  ),
        .in_id_i     ( in_id_i     ),
        .in_op_i     ( in_op_i     ),
        .in_opa_i    ( in_opa_i    ),
        .in_opb_i    ( in_opb_i    ),
        .out_valid_o ( out_valid_o ),
        .out_ready_i ( out_ready_i ),
        .out_id_o    ( out_id_o    ),
        .out_res_o   ( out_res_o   )
    );

    always #4 clk_i = ~clk_i;

    // Output ready with random runs while back-pressure is on
    initial begin
        int run_left;
        out_ready_i = 1'b1;
        run_left    = 0;
        forever begin
            @(posedge clk_i);
            #1;
            if (!bp_en) begin
                out_ready_i = 1'b1;
            end else if (run_left == 0) begin
                out_ready_i = 1'($urandom % 2);
                if ($urandom % 8 == 0) begin
                    run_left = 10 + int'($urandom % 20);
                end else begin
                    run_left = 1 + int'($urandom % 3);
                end
            end else begin
                run_left = run_left - 1;
            end
        end
    end

    // Outputs are sampled mid-cycle and transfer on the next rising edge
    always @(negedge clk_i) begin
        if (!rst_i && out_valid_o && out_ready_i) begin
            out_cnt = out_cnt + 1;
            if (rd_idx >= exp_q.size()) begin
                $display("Unexpected output at %0t: id %0d res %h with nothing outstanding",
                         $time, out_id_o, out_res_o);
                chk_err_cnt = chk_err_cnt + 1;
            end else begin
                cmp_entry = exp_q[rd_idx];
                rd_idx    = rd_idx + 1;
                if (out_id_o !== cmp_entry.id) begin
                    $display("CHECK FAILED at %0t: id %0d, expected %0d",
                             $time, out_id_o, cmp_entry.id);
                    chk_err_cnt = chk_err_cnt + 1;
                end
                if (out_res_o !== cmp_entry.res) begin
                    $display("CHECK FAILED at %0t: id %0d result %h, expected %h",
                             $time, cmp_entry.id, out_res_o, cmp_entry.res);
                    chk_err_cnt = chk_err_cnt + 1;
                end
            end
        end
    end

    // Called 1 ns after a rising edge and returns at the same phase
    task automatic send_instr(input logic [ID_W-1:0] id, input exec_op op,
                              input logic [DATA_W-1:0] a, input logic [DATA_W-1:0] b);
        int        waited;
        logic      done;
        exec_exp_t entry;
        in_valid_i = 1'b1;
        in_id_i    = id;
        in_op_i    = op;
        in_opa_i   = a;
        in_opb_i   = b;
        waited     = 0;
        done       = 1'b0;
        while (!done && waited < SEND_TIMEOUT) begin
            @(negedge clk_i);
            if (in_ready_o) begin
                entry.id  = id;
                entry.res = exec_ref(op, a, b);
                exp_q.push_back(entry);
                done = 1'b1;
            end
            @(posedge clk_i);
            #1;
            waited = waited + 1;
        end
        in_valid_i = 1'b0;
        if (!done) begin
            $display("Input stalled: id %0d not accepted within %0d cycles", id, SEND_TIMEOUT);
            stim_err_cnt = stim_err_cnt + 1;
        end
    endtask

    task automatic wait_drain(input int limit);
        int waited;
        waited = 0;
        while (rd_idx != exp_q.size() && waited < limit) begin
            @(posedge clk_i);
            #1;
            waited = waited + 1;
        end
        if (rd_idx != exp_q.size()) begin
            $display("Results missing: %0d still outstanding after %0d cycles",
                     exp_q.size() - rd_idx, limit);
            stim_err_cnt = stim_err_cnt + 1;
        end
    endtask

    task automatic report_test(input string name, input int errs_before);
        if (chk_err_cnt + stim_err_cnt == errs_before) begin
            pass_cnt = pass_cnt + 1;
            $display("PASS  %s", name);
        end else begin
            fail_cnt = fail_cnt + 1;
            $display("FAIL  %s", name);
        end
    endtask

    initial begin
        int errs;
        int outs_before;
        void'($urandom(SEED));
        rst_i        = 1'b1;
        in_valid_i   = 1'b0;
        in_id_i      = '0;
        in_op_i      = OP_ADD;
        in_opa_i     = '0;
        in_opb_i     = '0;
        bp_en        = 1'b0;
        rd_idx       = 0;
        out_cnt      = 0;
        chk_err_cnt  = 0;
        stim_err_cnt = 0;
        pass_cnt     = 0;
        fail_cnt     = 0;
        repeat (RESET_CYCLES) @(posedge clk_i);
        #1;
        rst_i = 1'b0;

        // Empty queue shows no valid and zero data
        errs = chk_err_cnt + stim_err_cnt;
        @(negedge clk_i);
        if (out_valid_o !== 1'b0 || in_ready_o !== 1'b1 ||
            out_id_o !== '0 || out_res_o !== '0) begin
            $display("CHECK FAILED at %0t: after reset out_valid_o %b in_ready_o %b",
                     $time, out_valid_o, in_ready_o);
            $display("CHECK FAILED at %0t: after reset out_id_o %0d out_res_o %h",
                     $time, out_id_o, out_res_o);
            stim_err_cnt = stim_err_cnt + 1;
        end
        @(posedge clk_i);
        #1;
        report_test("after reset", errs);

        errs = chk_err_cnt + stim_err_cnt;
        send_instr(3'd0, OP_ADD, 32'd5, 32'd7);
        send_instr(3'd1, OP_ADD, 32'hFFFF_FFFF, 32'd1);
        send_instr(3'd2, OP_SUB, 32'd3, 32'd5);
        send_instr(3'd3, OP_SUB, 32'h8000_0000, 32'h0000_0001);
        send_instr(3'd4, OP_AND, 32'hF0F0_1234, 32'h0FF0_FF00);
        send_instr(3'd5, OP_XOR, 32'hDEAD_BEEF, 32'hFFFF_0000);
        wait_drain(DRAIN_TIMEOUT);
        report_test("ALU operations", errs);

        errs = chk_err_cnt + stim_err_cnt;
        send_instr(3'd0, OP_MUL, 32'd0, 32'h0000_1234);
        send_instr(3'd1, OP_MUL, 32'd1, 32'h0000_ABCD);
        send_instr(3'd2, OP_MUL, 32'h0000_FFFF, 32'h0000_FFFF);
        send_instr(3'd3, OP_MUL, 32'h1234_0003, 32'hABCD_0005);
        send_instr(3'd4, OP_MUL, 32'hFFFF_8001, 32'h0001_00FF);
        wait_drain(DRAIN_TIMEOUT);
        report_test("multiply", errs);

        // ALU work behind a slow multiply must still leave after it
        errs = chk_err_cnt + stim_err_cnt;
        send_instr(3'd0, OP_MUL, 32'h0000_0123, 32'h0000_0456);
        send_instr(3'd1, OP_ADD, 32'd100, 32'd23);
        send_instr(3'd2, OP_XOR, 32'h5555_5555, 32'hAAAA_AAAA);
        send_instr(3'd3, OP_SUB, 32'd0, 32'd9);
        wait_drain(DRAIN_TIMEOUT);
        report_test("ordering", errs);

        errs        = chk_err_cnt + stim_err_cnt;
        outs_before = out_cnt;
        bp_en       = 1'b1;
        for (int i = 0; i < RANDOM_COUNT; i++) begin
            if ($urandom % 4 == 0) begin
                @(posedge clk_i);
                #1;
            end
            send_instr(ID_W'($urandom), exec_op'(3'($urandom % 5)), $urandom, $urandom);
        end
        wait_drain(DRAIN_TIMEOUT);
        bp_en = 1'b0;
        if (out_cnt - outs_before != RANDOM_COUNT) begin
            $display("CHECK FAILED at %0t: %0d outputs, expected %0d",
                     $time, out_cnt - outs_before, RANDOM_COUNT);
            stim_err_cnt = stim_err_cnt + 1;
        end
        report_test("random mix with back-pressure", errs);

        $display("Tests passed: %0d, failed: %0d, check errors: %0d",
                 pass_cnt, fail_cnt, chk_err_cnt + stim_err_cnt);
        if (fail_cnt == 0 && chk_err_cnt + stim_err_cnt == 0) begin
            $display("Verification passed");
        end else begin
            $display("Verification failed");
        end
        $finish;
    end

endmodule

// File: verilog/alu_unit.sv
// Single-stage ALU for add, subtract, and, xor.
// One result register that holds until the consumer takes it.

`timescale 1ns/1ns

module alu_unit import exec_mux_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ID_W-1:0]   in_id_i,
    input  exec_op            in_op_i,
    input  logic [DATA_W-1:0] in_opa_i,
    input  logic [DATA_W-1:0] in_opb_i,

    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [ID_W-1:0]   out_id_o,
    output logic [DATA_W-1:0] out_res_o
);

    logic              valid_q;
    logic [ID_W-1:0]   id_q;
    logic [DATA_W-1:0] res_q;
    logic [DATA_W-1:0] alu_res;
    logic              in_fire;

    // Accept when empty or when the held result leaves this cycle
    assign in_ready_o = ~valid_q | out_ready_i;
    assign in_fire    = in_valid_i & in_ready_o;

    always_comb begin
        case (in_op_i)
            OP_ADD:  alu_res = in_opa_i + in_opb_i;
            OP_SUB:  alu_res = in_opa_i - in_opb_i;
            OP_AND:  alu_res = in_opa_i & in_opb_i;
            OP_XOR:  alu_res = in_opa_i ^ in_opb_i;
            default: alu_res = '0;
        endcase
    end

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            valid_q <= 1'b0;
        end else if (in_fire) begin
            valid_q <= 1'b1;
        end else if (out_ready_i) begin
            valid_q <= 1'b0;
        end
    end

    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            id_q  <= in_id_i;
            res_q <= alu_res;
        end
    end

    assign out_valid_o = valid_q;
    assign out_id_o    = id_q;
    assign out_res_o   = res_q;

endmodule

// File: verilog/exec_mux_pkg.sv
// Shared widths, depths and enums for the execution-unit multiplexer.
// Modules and the testbench take these by wildcard import.

package exec_mux_pkg;

    // Operand and result width
    localparam int unsigned DATA_W = 32;

    // Instruction id width
    localparam int unsigned ID_W = 3;

    // Multiplier uses the low bits of each operand
    localparam int unsigned MUL_OPND_W = 16;
    localparam int unsigned MUL_CNT_W  = $clog2(MUL_OPND_W);

    // Order queue sizing
    localparam int unsigned ORDER_QUEUE_DEPTH = 4;
    localparam int unsigned ORDER_QUEUE_PTR_W = $clog2(ORDER_QUEUE_DEPTH);
    localparam int unsigned ORDER_QUEUE_CNT_W = $clog2(ORDER_QUEUE_DEPTH + 1);

    typedef enum logic [2:0] {
        OP_ADD = 3'd0,
        OP_SUB = 3'd1,
        OP_AND = 3'd2,
        OP_XOR = 3'd3,
        OP_MUL = 3'd4
    } exec_op;

    // Tag of the unit an instruction was sent to
    typedef enum logic [0:0] {
        UNIT_ALU = 1'b0,
        UNIT_MUL = 1'b1
    } exec_unit;

endpackage

// File: verilog/exec_unit_mux.sv
// Top level: dispatches each instruction to the ALU or the multiplier and
// returns results in acceptance order, using a queue of unit tags.

`timescale 1ns/1ns

module exec_unit_mux import exec_mux_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ID_W-1:0]   in_id_i,
    input  exec_op            in_op_i,
    input  logic [DATA_W-1:0] in_opa_i,
    input  logic [DATA_W-1:0] in_opb_i,

    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [ID_W-1:0]   out_id_o,
    output logic [DATA_W-1:0] out_res_o
);

    exec_unit          in_unit;
    logic              in_fire;
    logic              unit_ready;

    logic              alu_in_valid;
    logic              alu_in_ready;
    logic              alu_out_valid;
    logic              alu_out_ready;
    logic [ID_W-1:0]   alu_out_id;
    logic [DATA_W-1:0] alu_out_res;

    logic              mul_in_valid;
    logic              mul_in_ready;
    logic              mul_out_valid;
    logic              mul_out_ready;
    logic [ID_W-1:0]   mul_out_id;
    logic [DATA_W-1:0] mul_out_res;

    logic              queue_enq_ready;
    logic              queue_deq_valid;
    exec_unit          queue_head;

    // Dispatch
    assign in_unit    = (in_op_i == OP_MUL) ? UNIT_MUL : UNIT_ALU;
    assign unit_ready = (in_unit == UNIT_MUL) ? mul_in_ready : alu_in_ready;
    assign in_ready_o = unit_ready & queue_enq_ready;
    assign in_fire    = in_valid_i & in_ready_o;

    assign alu_in_valid = in_fire & (in_unit == UNIT_ALU);
    assign mul_in_valid = in_fire & (in_unit == UNIT_MUL);

    alu_unit alu_i (
        .clk_i       ( clk_i         ),
        .rst_i       ( rst_i         ),
        .in_valid_i  ( alu_in_valid  ),
        .in_ready_o  ( alu_in_ready  ),
        .in_id_i     ( in_id_i       ),
        .in_op_i     ( in_op_i       ),
        .in_opa_i    ( in_opa_i      ),
        .in_opb_i    ( in_opb_i      ),
        .out_valid_o ( alu_out_valid ),
        .out_ready_i ( alu_out_ready ),
        .out_id_o    ( alu_out_id    ),
        .out_res_o   ( alu_out_res   )
    );

    mul_unit mul_i (
        .clk_i       ( clk_i         ),
        .rst_i       ( rst_i         ),
        .in_valid_i  ( mul_in_valid  ),
        .in_ready_o  ( mul_in_ready  ),
        .in_id_i     ( in_id_i       ),
        .in_opa_i    ( in_opa_i      ),
        .in_opb_i    ( in_opb_i      ),
        .out_valid_o ( mul_out_valid ),
        .out_ready_i ( mul_out_ready ),
        .out_id_o    ( mul_out_id    ),
        .out_res_o   ( mul_out_res   )
    );

    unit_order_queue order_queue_i (
        .clk_i       ( clk_i                     ),
        .rst_i       ( rst_i                     ),
        .enq_valid_i ( in_fire                   ),
        .enq_ready_o ( queue_enq_ready           ),
        .enq_unit_i  ( in_unit                   ),
        .deq_ready_i ( out_valid_o & out_ready_i ),
        .deq_valid_o ( queue_deq_valid           ),
        .deq_unit_o  ( queue_head                )
    );

    // Only the unit at the head of the queue sees the output ready
    assign alu_out_ready = queue_deq_valid & (queue_head == UNIT_ALU) & out_ready_i;
    assign mul_out_ready = queue_deq_valid & (queue_head == UNIT_MUL) & out_ready_i;

    always_comb begin
        out_valid_o = 1'b0;
        out_id_o    = '0;
        out_res_o   = '0;
        if (queue_deq_valid) begin
            if (queue_head == UNIT_MUL) begin
                out_valid_o = mul_out_valid;
                out_id_o    = mul_out_id;
                out_res_o   = mul_out_res;
            end else begin
                out_valid_o = alu_out_valid;
                out_id_o    = alu_out_id;
                out_res_o   = alu_out_res;
            end
        end
    end

endmodule

// File: verilog/mul_unit.sv
// Iterative shift-add multiplier, 16x16 unsigned to a 32-bit product.
// Takes one multiplier bit per cycle and holds the product until taken.

`timescale 1ns/1ns

module mul_unit import exec_mux_pkg::*; (
    input  logic              clk_i,
    input  logic              rst_i,

    input  logic              in_valid_i,
    output logic              in_ready_o,
    input  logic [ID_W-1:0]   in_id_i,
    input  logic [DATA_W-1:0] in_opa_i,
    input  logic [DATA_W-1:0] in_opb_i,

    output logic              out_valid_o,
    input  logic              out_ready_i,
    output logic [ID_W-1:0]   out_id_o,
    output logic [DATA_W-1:0] out_res_o
);

    typedef enum logic [1:0] {
        MUL_IDLE,
        MUL_BUSY,
        MUL_DONE
    } mul_state_e;

    mul_state_e             state_q;
    logic [MUL_CNT_W-1:0]   cnt_q;
    logic [ID_W-1:0]        id_q;
    logic [DATA_W-1:0]      mcand_q;
    logic [MUL_OPND_W-1:0]  mplr_q;
    logic [DATA_W-1:0]      acc_q;
    logic                   in_fire;

    assign in_ready_o = state_q == MUL_IDLE;
    assign in_fire    = in_valid_i & in_ready_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            state_q <= MUL_IDLE;
            cnt_q   <= '0;
        end else begin
            case (state_q)
                MUL_IDLE: begin
                    if (in_fire) begin
                        state_q <= MUL_BUSY;
                        cnt_q   <= '0;
                    end
                end
                MUL_BUSY: begin
                    cnt_q <= cnt_q + 1'b1;
                    // Last multiplier bit is handled this cycle
                    if (cnt_q == MUL_CNT_W'(MUL_OPND_W - 1)) begin
                        state_q <= MUL_DONE;
                    end
                end
                MUL_DONE: begin
                    if (out_ready_i) begin
                        state_q <= MUL_IDLE;
                    end
                end
                default: state_q <= MUL_IDLE;
            endcase
        end
    end

    // Upper operand bits are ignored
    always_ff @(posedge clk_i) begin
        if (in_fire) begin
            id_q    <= in_id_i;
            mcand_q <= DATA_W'(in_opa_i[MUL_OPND_W-1:0]);
            mplr_q  <= in_opb_i[MUL_OPND_W-1:0];
            acc_q   <= '0;
        end else if (state_q == MUL_BUSY) begin
            if (mplr_q[0]) begin
                acc_q <= acc_q + mcand_q;
            end
            mcand_q <= mcand_q << 1;
            mplr_q  <= mplr_q >> 1;
        end
    end

    assign out_valid_o = state_q == MUL_DONE;
    assign out_id_o    = id_q;
    assign out_res_o   = acc_q;

endmodule

// File: verilog/unit_order_queue.sv
// FIFO of unit tags, one per accepted instruction.
// The head names the unit whose result may leave next.

`timescale 1ns/1ns

module unit_order_queue import exec_mux_pkg::*; (
    input  logic     clk_i,
    input  logic     rst_i,

    input  logic     enq_valid_i,
    output logic     enq_ready_o,
    input  exec_unit enq_unit_i,

    input  logic     deq_ready_i,
    output logic     deq_valid_o,
    output exec_unit deq_unit_o
);

    exec_unit                     mem_q [ORDER_QUEUE_DEPTH];
    logic [ORDER_QUEUE_PTR_W-1:0] rd_ptr_q;
    logic [ORDER_QUEUE_PTR_W-1:0] wr_ptr_q;
    logic [ORDER_QUEUE_CNT_W-1:0] count_q;
    logic                         enq_fire;
    logic                         deq_fire;

    assign enq_ready_o = count_q != ORDER_QUEUE_CNT_W'(ORDER_QUEUE_DEPTH);
    assign deq_valid_o = count_q != '0;
    assign deq_unit_o  = mem_q[rd_ptr_q];

    assign enq_fire = enq_valid_i & enq_ready_o;
    assign deq_fire = deq_ready_i & deq_valid_o;

    always_ff @(posedge clk_i) begin
        if (rst_i) begin
            rd_ptr_q <= '0;
            wr_ptr_q <= '0;
            count_q  <= '0;
        end else begin
            // Depth is a power of two, so the pointers wrap by themselves
            if (enq_fire) begin
                wr_ptr_q <= wr_ptr_q + 1'b1;
            end
            if (deq_fire) begin
                rd_ptr_q <= rd_ptr_q + 1'b1;
            end
            case ({enq_fire, deq_fire})
                2'b10:   count_q <= count_q + 1'b1;
                2'b01:   count_q <= count_q - 1'b1;
                default: count_q <= count_q;
            endcase
        end
    end

    always_ff @(posedge clk_i) begin
        if (enq_fire) begin
            mem_q[wr_ptr_q] <= enq_unit_i;
        end
    end

endmodule
